/* run.sh */
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal -f sim.f --top-module rfDecodeTb \
	-Mdir obj_dir -o rfDecodeSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/rfDecodeSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
	echo "Result: passed"
	exit 0
fi
echo "Result: failed"
exit 1

/* sim.f */
verilog/rfDecodePkg.sv
verilog/rfRegSpecDecoder.sv
verilog/rfImmDecoder.sv
verilog/rfPrecDecoder.sv
verilog/rfMemDecoder.sv
verilog/rfDecodeAssemble.sv
verilog/rfDecodeTop.sv
test/rfDecode_props.sv
test/rfDecodeTb.sv

/* test/rfDecodeTb.sv */
module rfDecodeTb import rfDecodePkg::*; ();

	localparam int ImmW       = 128;
	localparam int RandRuns   = 200;
	localparam int LatTimeout = 8;

	logic            clk;
	logic            arstN;
	fetchBufT        fetchBuf;
	decodeBusT       deco;
	logic [ImmW-1:0] decoImm;

	int errors;
	int checks;
	int seed;

	// Stimulus table and expected results, one entry per row
	fetchBufT        stimQ[$];
	decodeBusT       expQ[$];
	logic [ImmW-1:0] immQ[$];

	rfDecodeTop #(.ImmWidth(ImmW)) dut (
		.clk      (clk),
		.arstN    (arstN),
		.fetchBuf (fetchBuf),
		.deco     (deco),
		.decoImm  (decoImm)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ========================================
	// Helpers
	// ========================================
	task automatic checkVal(input logic [127:0] act, input logic [127:0] exp, input string msg);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail at %0t: %s, got %0h expected %0h", $time, msg, act, exp);
		end
	endtask

	function automatic logic [6:0] vecReg(input int n);
		return {1'b1, 6'(n)};
	endfunction

	// has is {hasRa, hasRb, hasRt}, wr is {rfWr, vrfWr}
	function automatic regDecoT regs(input logic [6:0] ra, input logic [6:0] rb,
		input logic [6:0] rt, input logic [2:0] has, input logic [1:0] wr);
		regDecoT r;
		r.Ra = regSpecT'(ra);
		r.Rb = regSpecT'(rb);
		r.Rt = regSpecT'(rt);
		{r.hasRa, r.hasRb, r.hasRt} = has;
		{r.rfWr, r.vrfWr} = wr;
		return r;
	endfunction

	// cls is {load, loadu, store, indexed}, flg is {br, cjb, csr}
	function automatic memDecoT mems(input logic [3:0] cls, input memSzT sz,
		input logic [2:0] flg, input logic [1:0] op);
		memDecoT m;
		{m.load, m.loadu, m.store, m.indexed} = cls;
		m.memSz = sz;
		{m.br, m.cjb, m.csr} = flg;
		m.csrOp = op;
		return m;
	endfunction

	// Instruction encoders for the fixed 48-bit format
	function automatic logic [47:0] insnReg(input logic [5:0] op, input logic [6:0] rt,
		input logic [6:0] ra, input logic [6:0] rb, input logic [5:0] fn, input logic [2:0] sz);
		logic [47:0] w;
		w = '0;
		w[5:0] = op;
		w[12:6] = rt;
		w[19:13] = ra;
		w[26:20] = rb;
		w[32:27] = fn;
		w[47:45] = sz;
		return w;
	endfunction

	function automatic logic [47:0] insnImm(input logic [5:0] op, input logic [6:0] rt,
		input logic [6:0] ra, input logic [18:0] imm, input logic [2:0] sz);
		logic [47:0] w;
		w = insnReg(op, rt, ra, 7'd0, 6'd0, sz);
		w[44:26] = imm;
		return w;
	endfunction

	function automatic logic [47:0] insnBcc(input logic [6:0] ra, input logic [6:0] rb,
		input logic [16:0] disp);
		logic [47:0] w;
		w = insnReg(OpBcc, 7'd0, ra, rb, 6'd0, 3'd0);
		w[44:28] = disp;
		return w;
	endfunction

	function automatic logic [47:0] insnCall(input logic [5:0] op, input logic [6:0] rt,
		input logic [34:0] tgt);
		logic [47:0] w;
		w = '0;
		w[5:0] = op;
		w[12:6] = rt;
		w[47:13] = tgt;
		return w;
	endfunction

	function automatic logic [47:0] insnCsr(input logic [6:0] rt, input logic [6:0] ra,
		input logic [15:0] num, input logic [1:0] fn);
		logic [47:0] w;
		w = insnReg(OpCsr, rt, ra, 7'd0, 6'd0, 3'd0);
		w[44:29] = num;
		w[28:27] = fn;
		return w;
	endfunction

	task automatic addRow(input logic [47:0] insn, input logic [2:0] sp, input logic vld,
		input regDecoT r, input memDecoT m, input prcT p, input logic vec, input logic steps,
		input logic [ImmW-1:0] imm);
		fetchBufT  f;
		decodeBusT e;
		f.valid = vld;
		f.spSel = sp;
		f.insn = insn;
		e.valid = vld;
		e.regDeco = r;
		e.memDeco = m;
		e.prc = p;
		e.isVector = vec;
		e.needSteps = steps;
		stimQ.push_back(f);
		expQ.push_back(e);
		immQ.push_back(imm);
	endtask

	// ========================================
	// Stimulus table
	// ========================================
	task automatic buildTable();
		memDecoT noMem;
		noMem = mems(4'b0000, Tetra, 3'b000, 2'd0);
		// Stack pointer remap over spSel 0 to 4, with precision codes
		addRow(insnReg(OpR2, 7'd5, 7'd47, 7'd47, FnAdd, 3'd2), 3'd0, 1'b1,
			regs(7'd47, 7'd47, 7'd5, 3'b111, 2'b10), noMem, Prc32, 1'b0, 1'b0, '0);
		addRow(insnReg(OpR2, 7'd47, 7'd47, 7'd47, FnAdd, 3'd1), 3'd1, 1'b1,
			regs(7'd60, 7'd60, 7'd60, 3'b111, 2'b10), noMem, Prc16, 1'b0, 1'b0, '0);
		addRow(insnReg(OpR2, 7'd3, 7'd47, 7'd4, FnAdd, 3'd3), 3'd2, 1'b1,
			regs(7'd61, 7'd4, 7'd3, 3'b111, 2'b10), noMem, Prc64, 1'b0, 1'b0, '0);
		addRow(insnReg(OpR2, 7'd3, 7'd4, 7'd47, FnAdd, 3'd4), 3'd3, 1'b1,
			regs(7'd4, 7'd62, 7'd3, 3'b111, 2'b10), noMem, Prc128, 1'b0, 1'b0, '0);
		addRow(insnReg(OpR2, 7'd47, 7'd1, 7'd2, FnAdd, 3'd0), 3'd4, 1'b1,
			regs(7'd1, 7'd2, 7'd63, 3'b111, 2'b10), noMem, Prc32, 1'b0, 1'b0, '0);
		// RET reads the link register, negative adjust
		addRow(insnImm(OpRet, 7'd10, 7'd47, 19'h40010, 3'd0), 3'd2, 1'b1,
			regs(7'd61, 7'd59, 7'd10, 3'b101, 2'b10), noMem, Prc32, 1'b0, 1'b0,
			{{109{1'b1}}, 19'h40010});
		// Vector target goes to the vector file only
		addRow(insnImm(OpAddi, vecReg(9), 7'd3, 19'h7fffe, 3'd1), 3'd0, 1'b1,
			regs(7'd3, 7'd0, vecReg(9), 3'b101, 2'b01), noMem, Prc16, 1'b1, 1'b0,
			{{109{1'b1}}, 19'h7fffe});
		// CALL with Rt zero writes nothing, BSR with Rt 1 writes
		addRow(insnCall(OpCall, 7'd0, 35'h400000000), 3'd0, 1'b1,
			regs(7'd0, 7'd0, 7'd0, 3'b001, 2'b00), mems(4'b0000, Tetra, 3'b010, 2'd0),
			Prc32, 1'b0, 1'b0, {{93{1'b1}}, 35'h400000000});
		addRow(insnCall(OpBsr, 7'd1, 35'h000100000), 3'd0, 1'b1,
			regs(7'd0, 7'd0, 7'd1, 3'b001, 2'b10), mems(4'b0000, Tetra, 3'b010, 2'd0),
			Prc32, 1'b0, 1'b0, 128'h100000);
		addRow(insnBcc(7'd3, 7'd4, 17'h10004), 3'd0, 1'b1,
			regs(7'd3, 7'd4, 7'd0, 3'b110, 2'b00), mems(4'b0000, Tetra, 3'b100, 2'd0),
			Prc32, 1'b0, 1'b0, {{111{1'b1}}, 17'h10004});
		// CSR number is zero-extended even with its top bit set
		addRow(insnCsr(7'd4, 7'd5, 16'h8123, 2'd2), 3'd0, 1'b1,
			regs(7'd5, 7'd0, 7'd4, 3'b101, 2'b10), mems(4'b0000, Tetra, 3'b001, 2'd2),
			Prc32, 1'b0, 1'b0, 128'h8123);
		// Invalid entry between valid ones
		addRow(insnReg(OpNop, 7'd0, 7'd0, 7'd0, 6'd0, 3'd0), 3'd0, 1'b0,
			regs(7'd0, 7'd0, 7'd0, 3'b000, 2'b00), noMem, Prc32, 1'b0, 1'b0, '0);
		// Scalar loads keep their size, undefined code gives Tetra
		addRow(insnImm(OpLoad, 7'd6, 7'd7, 19'h7ff00, 3'd3), 3'd0, 1'b1,
			regs(7'd7, 7'd0, 7'd6, 3'b101, 2'b10), mems(4'b1000, Octa, 3'b000, 2'd0),
			Prc32, 1'b0, 1'b0, {{109{1'b1}}, 19'h7ff00});
		addRow(insnImm(OpLoadu, 7'd6, 7'd7, 19'h00020, 3'd6), 3'd0, 1'b1,
			regs(7'd7, 7'd0, 7'd6, 3'b101, 2'b10), mems(4'b1100, Tetra, 3'b000, 2'd0),
			Prc32, 1'b0, 1'b0, 128'h20);
		// Vector accesses
		addRow(insnImm(OpLoad, 7'd6, vecReg(2), 19'h0, 3'd2), 3'd0, 1'b1,
			regs(vecReg(2), 7'd0, 7'd6, 3'b101, 2'b10), mems(4'b1000, Vect, 3'b000, 2'd0),
			Prc32, 1'b1, 1'b1, '0);
		addRow(insnImm(OpStore, vecReg(5), 7'd2, 19'h00020, 3'd3), 3'd0, 1'b1,
			regs(7'd2, 7'd0, vecReg(5), 3'b100, 2'b00), mems(4'b0010, Vect, 3'b000, 2'd0),
			Prc32, 1'b1, 1'b0, 128'h20);
		addRow(insnReg(OpR2, 7'd3, 7'd4, vecReg(8), FnLoadx, 3'd4), 3'd0, 1'b1,
			regs(7'd4, vecReg(8), 7'd3, 3'b111, 2'b10), mems(4'b1001, Vect, 3'b000, 2'd0),
			Prc32, 1'b1, 1'b1, '0);
		addRow(insnReg(OpCmp, 7'd8, 7'd9, 7'd10, 6'd0, 3'd4), 3'd0, 1'b1,
			regs(7'd9, 7'd10, 7'd8, 3'b111, 2'b10), noMem, Prc128, 1'b0, 1'b0, '0);
	endtask

	task automatic checkRow(input int i);
		checkVal(128'(deco), 128'(expQ[i]), $sformatf("row %0d decode bus", i));
		checkVal(decoImm, immQ[i], $sformatf("row %0d immediate", i));
	endtask

	// Counts falling edges until the bus turns valid
	task automatic waitValid(output int lat);
		int n;
		n = 0;
		lat = -1;
		while (lat < 0 && n < LatTimeout) begin
			@(negedge clk);
			n++;
			if (deco.valid) begin
				lat = n;
			end
		end
		if (lat < 0) begin
			errors++;
			$display("Timeout: deco.valid did not rise within %0d cycles", LatTimeout);
		end
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		int          lat;
		logic [31:0] rndHi;
		logic [31:0] rndLo;
		logic [31:0] rndCtl;
		errors = 0;
		checks = 0;
		seed = 32'h29fb;
		arstN = 1'b0;
		fetchBuf = '0;
		buildTable();

		repeat (5) @(negedge clk);
		arstN = 1'b1;
		@(negedge clk);
		checkVal(128'(deco.valid), '0, "deco.valid after reset");

		// First row also measures the latency
		fetchBuf = stimQ[0];
		waitValid(lat);
		checkVal(128'(lat), 128'(1), "latency of first entry");
		checkRow(0);

		// Back-to-back rows, each checked one rising edge later
		for (int i = 1; i < stimQ.size(); i++) begin
			fetchBuf = stimQ[i];
			@(negedge clk);
			checkRow(i);
		end

		// Random entries, invariants only
		for (int n = 0; n < RandRuns; n++) begin
			rndHi = $random(seed);
			rndLo = $random(seed);
			rndCtl = $random(seed);
			fetchBuf.insn = {rndHi[15:0], rndLo};
			fetchBuf.spSel = rndCtl[2:0];
			fetchBuf.valid = rndCtl[3];
			@(negedge clk);
			checkVal(128'(deco.valid), 128'(rndCtl[3]), "random valid follows input");
			checkVal(128'(deco.regDeco.rfWr & deco.regDeco.vrfWr), '0, "random write enables");
			checkVal(128'(deco.memDeco.memSz == Vect && !deco.isVector), '0,
				"random Vect without vector operand");
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* test/rfDecode_props.sv */
module rfDecodeProps import rfDecodePkg::*; (
	input logic      clk,
	input logic      arstN,
	input decodeBusT deco
);

	// ========================================
	// Decode bus invariants
	// ========================================

	// Only one register file takes the result
	assert property (@(posedge clk) disable iff (!arstN)
		!(deco.regDeco.rfWr && deco.regDeco.vrfWr))
		else $error("rfWr and vrfWr both set");

	// Bus stays invalid for the cycle after reset release
	assert property (@(posedge clk) $rose(arstN) |=> !deco.valid)
		else $error("deco.valid high in the cycle after reset");

	// A vector access always names a vector operand
	assert property (@(posedge clk) disable iff (!arstN)
		(deco.memDeco.memSz == Vect) |-> deco.isVector)
		else $error("memSz Vect without isVector");

endmodule

bind rfDecodeTop rfDecodeProps uProps (
	.clk   (clk),
	.arstN (arstN),
	.deco  (deco)
);

/* verilog/rfDecodeAssemble.sv */
module rfDecodeAssemble import rfDecodePkg::*; #(
	parameter int ImmWidth = 128
) (
	input  logic                clk,
	input  logic                arstN,
	input  logic                valid,
	input  regDecoT             regDeco,
	input  memDecoT             memDeco,
	input  prcT                 prc,
	input  logic [ImmWidth-1:0] imm,
	output decodeBusT           deco,
	output logic [ImmWidth-1:0] decoImm
);

	decodeBusT nxt;
	logic      rtUsed;
	logic      vecMem;

	// ========================================
	// Vector override
	// ========================================
	always_comb begin
		// Stores read their data through Rt, so a vector Rt counts for them too
		rtUsed = regDeco.hasRt || memDeco.store;

		nxt.valid   = valid;
		nxt.regDeco = regDeco;
		nxt.memDeco = memDeco;
		nxt.prc     = prc;

		nxt.isVector = (regDeco.hasRa && regDeco.Ra.vec) ||
			(regDeco.hasRb && regDeco.Rb.vec) ||
			(rtUsed && regDeco.Rt.vec);

		// Any vector address or data operand makes the access a vector one
		vecMem = (regDeco.hasRa && regDeco.Ra.vec) ||
			(memDeco.indexed && regDeco.Rb.vec) ||
			(rtUsed && regDeco.Rt.vec);
		if ((memDeco.load || memDeco.store) && vecMem) begin
			nxt.memDeco.memSz = Vect;
		end

		// Unit-stride with scalar base goes in one shot
		nxt.needSteps = nxt.memDeco.memSz == Vect &&
			!(!memDeco.indexed && !regDeco.Ra.vec);
	end

	// ========================================
	// Output register
	// ========================================
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			deco <= '0;
		end else begin
			deco <= nxt;
		end
	end

	always_ff @(posedge clk) begin
		decoImm <= imm;
	end

endmodule

/* verilog/rfDecodePkg.sv */
package rfDecodePkg;

	// ========================================
	// Instruction layout
	// ========================================
	localparam int InsnWidth = 48;
	localparam int OpBits    = 6;
	localparam int FnBits    = 6;
	// Register fields carry a vector flag over a 6-bit number
	localparam int RegBits   = 7;
	localparam int RtLsb     = 6;
	localparam int RaLsb     = 13;
	localparam int RbLsb     = 20;
	localparam int FnLsb     = 27;
	// Immediate, load/store and RET forms share one field
	localparam int ImmLsb    = 26;
	localparam int ImmBits   = 19;
	localparam int CsrLsb    = 29;
	localparam int CsrBits   = 16;
	localparam int CsrFnLsb  = 27;
	localparam int CsrFnBits = 2;
	localparam int DispLsb   = 28;
	localparam int DispBits  = 17;
	// Call target runs up to the top bit
	localparam int TgtLsb    = 13;
	localparam int TgtBits   = 35;
	localparam int SzLsb     = 45;
	localparam int SzBits    = 3;

	// ========================================
	// Opcodes and R2 functions
	// ========================================
	localparam logic [OpBits-1:0] OpR2    = 6'd2;
	localparam logic [OpBits-1:0] OpAddi  = 6'd4;
	localparam logic [OpBits-1:0] OpSubfi = 6'd5;
	localparam logic [OpBits-1:0] OpCsr   = 6'd7;
	localparam logic [OpBits-1:0] OpAndi  = 6'd8;
	localparam logic [OpBits-1:0] OpOri   = 6'd9;
	localparam logic [OpBits-1:0] OpXori  = 6'd10;
	localparam logic [OpBits-1:0] OpCmp   = 6'd12;
	localparam logic [OpBits-1:0] OpCmpi  = 6'd13;
	localparam logic [OpBits-1:0] OpCall  = 6'd20;
	localparam logic [OpBits-1:0] OpBsr   = 6'd21;
	localparam logic [OpBits-1:0] OpRet   = 6'd22;
	localparam logic [OpBits-1:0] OpBcc   = 6'd24;
	localparam logic [OpBits-1:0] OpLoad  = 6'd32;
	localparam logic [OpBits-1:0] OpLoadu = 6'd33;
	localparam logic [OpBits-1:0] OpStore = 6'd36;
	localparam logic [OpBits-1:0] OpNop   = 6'd63;

	localparam logic [FnBits-1:0] FnAdd    = 6'd4;
	localparam logic [FnBits-1:0] FnSub    = 6'd5;
	localparam logic [FnBits-1:0] FnAnd    = 6'd8;
	localparam logic [FnBits-1:0] FnOr     = 6'd9;
	localparam logic [FnBits-1:0] FnXor    = 6'd10;
	localparam logic [FnBits-1:0] FnSll    = 6'd16;
	localparam logic [FnBits-1:0] FnSrl    = 6'd17;
	localparam logic [FnBits-1:0] FnSra    = 6'd18;
	localparam logic [FnBits-1:0] FnLoadx  = 6'd32;
	localparam logic [FnBits-1:0] FnLoadux = 6'd33;
	localparam logic [FnBits-1:0] FnStorex = 6'd36;

	// Register conventions
	localparam logic [RegBits-1:0] SpAlias = 7'd47;
	localparam logic [RegBits-1:0] SpBase  = 7'd60;
	localparam logic [RegBits-1:0] LinkReg = 7'd59;

	// ========================================
	// Types
	// ========================================
	typedef enum logic [2:0] {Prc8, Prc16, Prc32, Prc64, Prc128} prcT;
	typedef enum logic [2:0] {Byt, Wyde, Tetra, Octa, Hexi, Vect} memSzT;

	typedef struct packed {
		logic               vec;
		logic [RegBits-2:0] num;
	} regSpecT;

	typedef struct packed {
		logic                 valid;
		logic [2:0]           spSel;
		logic [InsnWidth-1:0] insn;
	} fetchBufT;

	typedef struct packed {
		regSpecT Ra;
		regSpecT Rb;
		regSpecT Rt;
		logic    hasRa;
		logic    hasRb;
		logic    hasRt;
		logic    rfWr;
		logic    vrfWr;
	} regDecoT;

	typedef struct packed {
		logic                 load;
		logic                 loadu;
		logic                 store;
		logic                 indexed;
		memSzT                memSz;
		logic                 br;
		logic                 cjb;
		logic                 csr;
		logic [CsrFnBits-1:0] csrOp;
	} memDecoT;

	typedef struct packed {
		logic    valid;
		regDecoT regDeco;
		memDecoT memDeco;
		prcT     prc;
		logic    isVector;
		logic    needSteps;
	} decodeBusT;

endpackage

/* verilog/rfDecodeTop.sv */
module rfDecodeTop import rfDecodePkg::*; #(
	parameter int ImmWidth = 128
) (
	input  logic                clk,
	input  logic                arstN,
	input  fetchBufT            fetchBuf,
	output decodeBusT           deco,
	output logic [ImmWidth-1:0] decoImm
);

	regDecoT             regDeco;
	memDecoT             memDeco;
	prcT                 prc;
	logic [ImmWidth-1:0] imm;

	// Combinational decode of the fetch buffer entry
	rfRegSpecDecoder uRegSpec (
		.fetchBuf (fetchBuf),
		.regDeco  (regDeco)
	);

	rfImmDecoder #(.ImmWidth(ImmWidth)) uImm (
		.fetchBuf (fetchBuf),
		.imm      (imm)
	);

	rfPrecDecoder uPrec (
		.fetchBuf (fetchBuf),
		.prc      (prc)
	);

	rfMemDecoder uMem (
		.fetchBuf (fetchBuf),
		.memDeco  (memDeco)
	);

	// One register stage to the decode bus
	rfDecodeAssemble #(.ImmWidth(ImmWidth)) uAssemble (
		.clk     (clk),
		.arstN   (arstN),
		.valid   (fetchBuf.valid),
		.regDeco (regDeco),
		.memDeco (memDeco),
		.prc     (prc),
		.imm     (imm),
		.deco    (deco),
		.decoImm (decoImm)
	);

endmodule

/* verilog/rfImmDecoder.sv */
module rfImmDecoder import rfDecodePkg::*; #(
	parameter int ImmWidth = 128
) (
	input  fetchBufT            fetchBuf,
	output logic [ImmWidth-1:0] imm
);

	logic [OpBits-1:0]   opc;
	logic [ImmBits-1:0]  immFld;
	logic [DispBits-1:0] disp;
	logic [TgtBits-1:0]  tgt;
	logic [CsrBits-1:0]  csrNum;

	// Raw fields where the opcode decides which one counts
	assign opc    = fetchBuf.insn[OpBits-1:0];
	assign immFld = fetchBuf.insn[ImmLsb +: ImmBits];
	assign disp   = fetchBuf.insn[DispLsb +: DispBits];
	assign tgt    = fetchBuf.insn[TgtLsb +: TgtBits];
	assign csrNum = fetchBuf.insn[CsrLsb +: CsrBits];

	always_comb begin
		case (opc)
		// Immediate arithmetic and compare, load/store displacement and RET adjust
		OpAddi, OpSubfi, OpAndi, OpOri, OpXori, OpCmpi, OpLoad, OpLoadu, OpStore, OpRet:
			imm = {{(ImmWidth-ImmBits){immFld[ImmBits-1]}}, immFld};
		OpBcc:
			imm = {{(ImmWidth-DispBits){disp[DispBits-1]}}, disp};
		OpCall, OpBsr:
			imm = {{(ImmWidth-TgtBits){tgt[TgtBits-1]}}, tgt};
		// CSR number is unsigned
		OpCsr:
			imm = {{(ImmWidth-CsrBits){1'b0}}, csrNum};
		default:
			imm = '0;
		endcase
	end

endmodule

/* verilog/rfMemDecoder.sv */
module rfMemDecoder import rfDecodePkg::*; (
	input  fetchBufT fetchBuf,
	output memDecoT  memDeco
);

	logic [OpBits-1:0] opc;
	logic [FnBits-1:0] fn;
	logic              isR2;

	assign opc  = fetchBuf.insn[OpBits-1:0];
	assign fn   = fetchBuf.insn[FnLsb +: FnBits];
	assign isR2 = opc == OpR2;

	always_comb begin
		// Load/store class
		memDeco.load    = opc inside {OpLoad, OpLoadu} || (isR2 && fn inside {FnLoadx, FnLoadux});
		memDeco.loadu   = opc == OpLoadu || (isR2 && fn == FnLoadux);
		memDeco.store   = opc == OpStore || (isR2 && fn == FnStorex);
		memDeco.indexed = isR2 && fn inside {FnLoadx, FnLoadux, FnStorex};

		// Access size from the size field
		memDeco.memSz = Tetra;
		if (memDeco.load || memDeco.store) begin
			case (prcT'(fetchBuf.insn[SzLsb +: SzBits]))
			Prc8:    memDeco.memSz = Byt;
			Prc16:   memDeco.memSz = Wyde;
			Prc32:   memDeco.memSz = Tetra;
			Prc64:   memDeco.memSz = Octa;
			Prc128:  memDeco.memSz = Hexi;
			default: memDeco.memSz = Tetra;
			endcase
		end

		// Flow control and CSR
		memDeco.br    = opc == OpBcc;
		memDeco.cjb   = opc inside {OpCall, OpBsr};
		memDeco.csr   = opc == OpCsr;
		memDeco.csrOp = memDeco.csr ? fetchBuf.insn[CsrFnLsb +: CsrFnBits] : '0;
	end

endmodule

/* verilog/rfPrecDecoder.sv */
module rfPrecDecoder import rfDecodePkg::*; (
	input  fetchBufT fetchBuf,
	output prcT      prc
);

	logic [OpBits-1:0] opc;
	logic [FnBits-1:0] fn;
	logic              sizable;
	prcT               sz;

	assign opc = fetchBuf.insn[OpBits-1:0];
	assign fn  = fetchBuf.insn[FnLsb +: FnBits];
	assign sz  = prcT'(fetchBuf.insn[SzLsb +: SzBits]);

	// Only ALU, shift and compare ops honour the size field
	always_comb begin
		sizable = 1'b0;
		case (opc)
		OpR2:
			sizable = fn inside {FnAdd, FnSub, FnAnd, FnOr, FnXor, FnSll, FnSrl, FnSra};
		OpAddi, OpSubfi, OpAndi, OpOri, OpXori:
			sizable = 1'b1;
		OpCmp, OpCmpi:
			sizable = 1'b1;
		default:
			sizable = 1'b0;
		endcase
	end

	// 32 bits unless the op asks for 16, 64 or 128
	assign prc = (sizable && sz inside {Prc16, Prc64, Prc128}) ? sz : Prc32;

endmodule

/* verilog/rfRegSpecDecoder.sv */
module rfRegSpecDecoder import rfDecodePkg::*; (
	input  fetchBufT fetchBuf,
	output regDecoT  regDeco
);

	// Alias 47 picks one of the four banked stack pointers, select 0 leaves it alone
	function automatic regSpecT spRemap(input regSpecT r, input logic [2:0] sel);
		regSpecT res;
		res = r;
		if (r == SpAlias && sel >= 3'd1 && sel <= 3'd4) begin
			res = regSpecT'(SpBase + RegBits'(sel) - 7'd1);
		end
		return res;
	endfunction

	logic [OpBits-1:0] opc;
	logic [FnBits-1:0] fn;
	logic              r2Alu;
	logic              immAlu;
	logic              isLoad;
	logic              isStore;
	regSpecT           rawRb;

	assign opc = fetchBuf.insn[OpBits-1:0];
	assign fn  = fetchBuf.insn[FnLsb +: FnBits];

	// Arithmetic, logic and shift functions of the R2 form
	assign r2Alu = opc == OpR2 &&
		(fn inside {FnAdd, FnSub, FnAnd, FnOr, FnXor, FnSll, FnSrl, FnSra});
	assign immAlu = opc inside {OpAddi, OpSubfi, OpAndi, OpOri, OpXori};
	assign isLoad = opc inside {OpLoad, OpLoadu} ||
		(opc == OpR2 && fn inside {FnLoadx, FnLoadux});
	assign isStore = opc == OpStore || (opc == OpR2 && fn == FnStorex);

	// RET takes its return address from the link register
	assign rawRb = (opc == OpRet) ? regSpecT'(LinkReg) :
		regSpecT'(fetchBuf.insn[RbLsb +: RegBits]);

	always_comb begin
		// Stack pointer remap after the RET override
		regDeco.Ra = spRemap(regSpecT'(fetchBuf.insn[RaLsb +: RegBits]), fetchBuf.spSel);
		regDeco.Rb = spRemap(rawRb, fetchBuf.spSel);
		regDeco.Rt = spRemap(regSpecT'(fetchBuf.insn[RtLsb +: RegBits]), fetchBuf.spSel);

		// Operand presence
		regDeco.hasRa = !(opc inside {OpNop, OpCall, OpBsr});
		regDeco.hasRb = opc inside {OpR2, OpCmp, OpBcc};
		regDeco.hasRt = !(opc inside {OpBcc, OpNop} || isStore);

		// Write enables, vector flag of Rt steers to the vector file
		regDeco.rfWr  = 1'b0;
		regDeco.vrfWr = 1'b0;
		if (r2Alu || immAlu || isLoad || opc inside {OpCmp, OpCmpi, OpCsr}) begin
			regDeco.vrfWr = regDeco.Rt.vec;
			regDeco.rfWr  = !regDeco.Rt.vec;
		end else if (opc inside {OpCall, OpBsr, OpRet}) begin
			// Link writes only when a target register is named
			regDeco.rfWr = regDeco.Rt != '0;
		end
	end

endmodule
